//--- hdl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	//==================================================
	// Bus widths and payload types

	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	//==================================================
	// I/O bridge sequencing

	typedef enum logic [1:0] {
		IDLE,
		FAR_REQ,	// select out to the far device
		FAR_WAIT,
		NEAR_ACK
	} bridge_state_t;

endpackage

`default_nettype wire

//--- hdl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	//==================================================
	// Near bus regions, address bits 31..28

	typedef enum logic [3:0] {
		REGION_ROM = 4'h0,
		REGION_IO  = 4'h5
	} region_t;

	// Far devices behind the bridge, address bits 27..24
	typedef enum logic [3:0] {
		DEV_TIMER  = 4'h5,
		DEV_IRQ    = 4'h8,
		DEV_SYSREG = 4'h9
	} device_t;

	//==================================================
	// Register offsets, address bits 4..2

	typedef enum logic [2:0] {
		TMR_COUNT   = 3'd0,
		TMR_COMPARE = 3'd1,
		TMR_CTRL    = 3'd2
	} timer_reg_t;

	typedef enum logic [2:0] {
		IRQ_PENDING = 3'd0,
		IRQ_ENABLE  = 3'd1,
		IRQ_CLAIM   = 3'd2
	} irq_reg_t;

	typedef enum logic [2:0] {
		SR_DEVICE_ID = 3'd0,
		SR_LEDS      = 3'd1,
		SR_RESET     = 3'd2
	} sysreg_reg_t;

	// Boot ROM, word index from address bits 5..2
	localparam int    ROM_WORDS = 16;
	localparam int    ROM_IDX_W = $clog2(ROM_WORDS);
	localparam string ROM_FILE  = "rom_init.hex";

	localparam int DEVICE_ID   = 6;
	localparam int LED_W       = 8;
	localparam int IRQ_SOURCES = 4;

	// Internal reset length after a software reset
	localparam int RESET_HOLD = 16;
	localparam int HOLD_W     = $clog2(RESET_HOLD + 1);

endpackage

`default_nettype wire

//--- hdl/reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
	input  wire  i_clock,
	input  wire  i_rst_n,
	input  wire  i_soft_reset,
	output logic o_rst_n
);

	import soc_map_pkg::*;

	logic              sync_q;
	logic [HOLD_W-1:0] hold_cnt;

	// Asserts at once, releases on the second edge after i_rst_n rises
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_q   <= 1'b0;
			hold_cnt <= '0;
			o_rst_n  <= 1'b0;
		end else begin
			sync_q <= 1'b1;
			if (i_soft_reset)
				hold_cnt <= HOLD_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			// Low for RESET_HOLD edges once the pulse is seen
			o_rst_n <= sync_q && !i_soft_reset && (hold_cnt <= HOLD_W'(1));
		end
	end

endmodule

`default_nettype wire

//--- hdl/system_bus.sv
`timescale 1ns/1ps
`default_nettype none

module system_bus (
	input  wire                 i_clock,
	input  wire                 i_rst_n,

	// Wishbone classic slave
	input  wire                 i_wb_cyc,
	input  wire                 i_wb_stb,
	input  wire                 i_wb_we,
	input  wire soc_bus_pkg::addr_t i_wb_adr,
	input  wire soc_bus_pkg::word_t i_wb_dat,
	output soc_bus_pkg::word_t  o_wb_dat,
	output logic                o_wb_ack,

	// Near side of the I/O bridge
	output logic                o_io_req,
	output logic                o_io_we,
	output logic [27:0]         o_io_offset,
	output soc_bus_pkg::word_t  o_io_wdata,
	input  wire soc_bus_pkg::word_t i_io_rdata,
	input  wire                 i_io_ack
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	region_t              region;
	logic                 start;
	logic                 busy;
	logic                 local_ack;
	word_t                local_rdata;
	logic [ROM_IDX_W-1:0] rom_idx;
	word_t                rom [ROM_WORDS];

	initial $readmemh(ROM_FILE, rom);

	assign region  = region_t'(i_wb_adr[31:28]);
	assign rom_idx = i_wb_adr[ROM_IDX_W+1:2];

	// Master holds stb until ack, so accept once per transfer
	assign start = i_wb_cyc && i_wb_stb && !busy;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy      <= 1'b0;
			local_ack <= 1'b0;
			o_io_req  <= 1'b0;
		end else begin
			local_ack <= 1'b0;
			o_io_req  <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				if (region == REGION_IO)
					o_io_req <= 1'b1;
				else
					local_ack <= 1'b1;
			end else if (o_wb_ack) begin
				busy <= 1'b0;
			end
		end
	end

	// ROM writes and unmapped regions answer zero
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_io_we     <= i_wb_we;
			o_io_offset <= i_wb_adr[27:0];
			o_io_wdata  <= i_wb_dat;
			if (region == REGION_ROM && !i_wb_we)
				local_rdata <= rom[rom_idx];
			else
				local_rdata <= '0;
		end
	end

	// Bridge response goes straight through
	assign o_wb_ack = local_ack || i_io_ack;
	assign o_wb_dat = i_io_ack ? i_io_rdata : local_rdata;

endmodule

`default_nettype wire

//--- hdl/io_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module io_bridge (
	input  wire                 i_clock,
	input  wire                 i_rst_n,

	// Near side
	input  wire                 i_req,
	input  wire                 i_we,
	input  wire [27:0]          i_offset,
	input  wire soc_bus_pkg::word_t i_wdata,
	output soc_bus_pkg::word_t  o_rdata,
	output logic                o_ack,

	// Far side, shared by all devices
	output logic                o_far_we,
	output logic [2:0]          o_far_index,
	output soc_bus_pkg::word_t  o_far_wdata,
	output logic                o_timer_sel,
	output logic                o_irq_sel,
	output logic                o_sysreg_sel,
	input  wire soc_bus_pkg::word_t i_timer_rdata,
	input  wire                 i_timer_ack,
	input  wire soc_bus_pkg::word_t i_irq_rdata,
	input  wire                 i_irq_ack,
	input  wire soc_bus_pkg::word_t i_sysreg_rdata,
	input  wire                 i_sysreg_ack
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	bridge_state_t state;
	logic          we_r;
	logic [2:0]    index_r;
	word_t         wdata_r;
	device_t       dev_r;
	logic          far_ack;
	word_t         far_rdata;

	//==================================================
	// Sequencing

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_ack <= 1'b0;
		end else begin
			o_ack <= 1'b0;
			case (state)
				IDLE: begin
					if (i_req)
						state <= FAR_REQ;
				end
				FAR_REQ: state <= FAR_WAIT;
				FAR_WAIT: begin
					if (far_ack) begin
						o_ack <= 1'b1;
						state <= NEAR_ACK;
					end
				end
				NEAR_ACK: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == IDLE && i_req) begin
			we_r    <= i_we;
			index_r <= i_offset[4:2];
			wdata_r <= i_wdata;
			dev_r   <= device_t'(i_offset[27:24]);
		end
		if (state == FAR_WAIT && far_ack)
			o_rdata <= far_rdata;
	end

	//==================================================
	// Device decode and response mux

	// One select, held for the single FAR_REQ cycle
	assign o_timer_sel  = (state == FAR_REQ) && (dev_r == DEV_TIMER);
	assign o_irq_sel    = (state == FAR_REQ) && (dev_r == DEV_IRQ);
	assign o_sysreg_sel = (state == FAR_REQ) && (dev_r == DEV_SYSREG);

	assign o_far_we    = we_r;
	assign o_far_index = index_r;
	assign o_far_wdata = wdata_r;

	always_comb begin
		case (dev_r)
			DEV_TIMER: begin
				far_ack   = i_timer_ack;
				far_rdata = i_timer_rdata;
			end
			DEV_IRQ: begin
				far_ack   = i_irq_ack;
				far_rdata = i_irq_rdata;
			end
			DEV_SYSREG: begin
				far_ack   = i_sysreg_ack;
				far_rdata = i_sysreg_rdata;
			end
			// Nothing there, answer zero on time
			default: begin
				far_ack   = 1'b1;
				far_rdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/sys_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sys_timer (
	input  wire                 i_clock,
	input  wire                 i_rst_n,
	input  wire                 i_sel,
	input  wire                 i_we,
	input  wire [2:0]           i_index,
	input  wire soc_bus_pkg::word_t i_wdata,
	output soc_bus_pkg::word_t  o_rdata,
	output logic                o_ack,
	output logic                o_irq
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	timer_reg_t reg_sel;
	logic       wr;
	word_t      count;
	word_t      compare;
	logic       irq_en;

	assign reg_sel = timer_reg_t'(i_index);
	assign wr      = i_sel && i_we;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count   <= '0;
			compare <= '1;
			irq_en  <= 1'b0;
			o_ack   <= 1'b0;
			o_irq   <= 1'b0;
		end else begin
			o_ack <= i_sel;
			// Free running unless software loads it
			if (wr && reg_sel == TMR_COUNT)
				count <= i_wdata;
			else
				count <= count + 1'b1;
			if (wr && reg_sel == TMR_COMPARE)
				compare <= i_wdata;
			if (wr && reg_sel == TMR_CTRL)
				irq_en <= i_wdata[0];
			o_irq <= irq_en && (count >= compare);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_sel) begin
			case (reg_sel)
				TMR_COUNT:   o_rdata <= count;
				TMR_COMPARE: o_rdata <= compare;
				TMR_CTRL:    o_rdata <= word_t'(irq_en);
				default:     o_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
	input  wire                 i_clock,
	input  wire                 i_rst_n,
	input  wire [soc_map_pkg::IRQ_SOURCES-1:0] i_src,
	input  wire                 i_sel,
	input  wire                 i_we,
	input  wire [2:0]           i_index,
	input  wire soc_bus_pkg::word_t i_wdata,
	output soc_bus_pkg::word_t  o_rdata,
	output logic                o_ack,
	output logic                o_irq
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	irq_reg_t               reg_sel;
	logic                   claim_rd;
	logic [IRQ_SOURCES-1:0] src_q;
	logic [IRQ_SOURCES-1:0] pending;
	logic [IRQ_SOURCES-1:0] enable;
	logic [IRQ_SOURCES-1:0] active;
	logic [IRQ_SOURCES-1:0] claim_mask;
	word_t                  claim_id;

	assign reg_sel  = irq_reg_t'(i_index);
	assign claim_rd = i_sel && !i_we && (reg_sel == IRQ_CLAIM);
	assign active   = pending & enable;
	assign o_irq    = |active;

	// Lowest numbered active source wins the claim
	always_comb begin
		claim_id   = '0;
		claim_mask = '0;
		for (int i = IRQ_SOURCES - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_id   = word_t'(i + 1);
				claim_mask = IRQ_SOURCES'(1) << i;
			end
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			src_q   <= '0;
			pending <= '0;
			enable  <= '0;
			o_ack   <= 1'b0;
		end else begin
			o_ack <= i_sel;
			src_q <= i_src;
			// A new edge beats a claim on the same source
			pending <= (pending & ~({IRQ_SOURCES{claim_rd}} & claim_mask)) | (i_src & ~src_q);
			if (i_sel && i_we && reg_sel == IRQ_ENABLE)
				enable <= i_wdata[IRQ_SOURCES-1:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_sel) begin
			case (reg_sel)
				IRQ_PENDING: o_rdata <= word_t'(pending);
				IRQ_ENABLE:  o_rdata <= word_t'(enable);
				IRQ_CLAIM:   o_rdata <= claim_id;
				default:     o_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/sys_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
	input  wire                 i_clock,
	input  wire                 i_rst_n,
	input  wire                 i_sel,
	input  wire                 i_we,
	input  wire [2:0]           i_index,
	input  wire soc_bus_pkg::word_t i_wdata,
	output soc_bus_pkg::word_t  o_rdata,
	output logic                o_ack,
	output logic [soc_map_pkg::LED_W-1:0] o_leds,
	output logic                o_soft_reset
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	sysreg_reg_t reg_sel;
	logic        wr;
	logic        reset_hit;
	logic [1:0]  reset_dly;
	word_t       leds_r;

	assign reg_sel   = sysreg_reg_t'(i_index);
	assign wr        = i_sel && i_we;
	assign reset_hit = wr && (reg_sel == SR_RESET) && i_wdata[0];
	assign o_leds    = leds_r[LED_W-1:0];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			leds_r       <= '0;
			o_ack        <= 1'b0;
			reset_dly    <= '0;
			o_soft_reset <= 1'b0;
		end else begin
			o_ack <= i_sel;
			if (wr && reg_sel == SR_LEDS)
				leds_r <= i_wdata;
			// Held back until the bridge ack has reached the master
			reset_dly    <= {reset_dly[0], reset_hit};
			o_soft_reset <= reset_dly[1];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_sel) begin
			case (reg_sel)
				SR_DEVICE_ID: o_rdata <= word_t'(DEVICE_ID);
				SR_LEDS:      o_rdata <= leds_r;
				default:      o_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input  wire                 i_clock,
	input  wire                 i_rst_n,

	input  wire                 i_wb_cyc,
	input  wire                 i_wb_stb,
	input  wire                 i_wb_we,
	input  wire soc_bus_pkg::addr_t i_wb_adr,
	input  wire soc_bus_pkg::word_t i_wb_dat,
	output soc_bus_pkg::word_t  o_wb_dat,
	output logic                o_wb_ack,

	input  wire [soc_map_pkg::IRQ_SOURCES-1:0] i_irq_src,
	output logic                o_irq_timer,
	output logic                o_irq_ext,
	output logic [soc_map_pkg::LED_W-1:0] o_leds
);

	import soc_bus_pkg::*;

	logic       rst_n;
	logic       soft_reset;

	logic       io_req;
	logic       io_we;
	logic [27:0] io_offset;
	word_t      io_wdata;
	word_t      io_rdata;
	logic       io_ack;

	logic       far_we;
	logic [2:0] far_index;
	word_t      far_wdata;
	logic       timer_sel;
	word_t      timer_rdata;
	logic       timer_ack;
	logic       irq_sel;
	word_t      irq_rdata;
	logic       irq_ack;
	logic       sysreg_sel;
	word_t      sysreg_rdata;
	logic       sysreg_ack;

	//==================================================
	// Reset and near bus

	reset_sync u_reset_sync (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_soft_reset (soft_reset),
		.o_rst_n      (rst_n)
	);

	system_bus u_system_bus (
		.i_clock     (i_clock),
		.i_rst_n     (rst_n),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_io_req    (io_req),
		.o_io_we     (io_we),
		.o_io_offset (io_offset),
		.o_io_wdata  (io_wdata),
		.i_io_rdata  (io_rdata),
		.i_io_ack    (io_ack)
	);

	//==================================================
	// Bridge and far devices

	io_bridge u_io_bridge (
		.i_clock        (i_clock),
		.i_rst_n        (rst_n),
		.i_req          (io_req),
		.i_we           (io_we),
		.i_offset       (io_offset),
		.i_wdata        (io_wdata),
		.o_rdata        (io_rdata),
		.o_ack          (io_ack),
		.o_far_we       (far_we),
		.o_far_index    (far_index),
		.o_far_wdata    (far_wdata),
		.o_timer_sel    (timer_sel),
		.o_irq_sel      (irq_sel),
		.o_sysreg_sel   (sysreg_sel),
		.i_timer_rdata  (timer_rdata),
		.i_timer_ack    (timer_ack),
		.i_irq_rdata    (irq_rdata),
		.i_irq_ack      (irq_ack),
		.i_sysreg_rdata (sysreg_rdata),
		.i_sysreg_ack   (sysreg_ack)
	);

	sys_timer u_sys_timer (
		.i_clock (i_clock),
		.i_rst_n (rst_n),
		.i_sel   (timer_sel),
		.i_we    (far_we),
		.i_index (far_index),
		.i_wdata (far_wdata),
		.o_rdata (timer_rdata),
		.o_ack   (timer_ack),
		.o_irq   (o_irq_timer)
	);

	irq_ctrl u_irq_ctrl (
		.i_clock (i_clock),
		.i_rst_n (rst_n),
		.i_src   (i_irq_src),
		.i_sel   (irq_sel),
		.i_we    (far_we),
		.i_index (far_index),
		.i_wdata (far_wdata),
		.o_rdata (irq_rdata),
		.o_ack   (irq_ack),
		.o_irq   (o_irq_ext)
	);

	sys_regs u_sys_regs (
		.i_clock      (i_clock),
		.i_rst_n      (rst_n),
		.i_sel        (sysreg_sel),
		.i_we         (far_we),
		.i_index      (far_index),
		.i_wdata      (far_wdata),
		.o_rdata      (sysreg_rdata),
		.o_ack        (sysreg_ack),
		.o_leds       (o_leds),
		.o_soft_reset (soft_reset)
	);

endmodule

`default_nettype wire

//--- verif/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int ACK_LIMIT    = 16;
	localparam int IO_LATENCY   = 4;
	localparam int NEAR_LATENCY = 1;

	localparam int N_ROM        = 24;
	localparam int N_UNMAPPED   = 16;
	localparam int N_LED        = 12;
	localparam int N_UNKNOWN    = 4;
	localparam int N_IRQ_ROUNDS = 10;

	// Bus transactions per section plus slack for pulses and reset waits
	localparam int TXN_COUNT = N_ROM + 2 + N_UNMAPPED + 2 + 2 * N_LED + N_UNKNOWN
		+ 8 + 8 * N_IRQ_ROUNDS + 12;
	localparam int WATCHDOG_NS = TXN_COUNT * 20 * CLK_PERIOD + 1000;

	logic                   clock = 1'b0;
	logic                   rst_n;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic                   wb_we;
	addr_t                  wb_adr;
	word_t                  wb_dat_in;
	word_t                  wb_dat_out;
	logic                   wb_ack;
	logic [IRQ_SOURCES-1:0] irq_src;
	logic                   irq_timer;
	logic                   irq_ext;
	logic [LED_W-1:0]       leds;

	integer seed;

	// Reference model state
	word_t                  rom_model [ROM_WORDS];
	logic [LED_W-1:0]       led_model;
	logic [IRQ_SOURCES-1:0] enable_model;
	logic [IRQ_SOURCES-1:0] pending_model;

	soc_top u_dut (
		.i_clock     (clock),
		.i_rst_n     (rst_n),
		.i_wb_cyc    (wb_cyc),
		.i_wb_stb    (wb_stb),
		.i_wb_we     (wb_we),
		.i_wb_adr    (wb_adr),
		.i_wb_dat    (wb_dat_in),
		.o_wb_dat    (wb_dat_out),
		.o_wb_ack    (wb_ack),
		.i_irq_src   (irq_src),
		.o_irq_timer (irq_timer),
		.o_irq_ext   (irq_ext),
		.o_leds      (leds)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	//==================================================
	// Compare tasks

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic check_leds(input string name, input logic [LED_W-1:0] expected,
			input logic [LED_W-1:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic check_cycles(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	//==================================================
	// Wishbone master

	function automatic word_t next_word();
		return word_t'($random(seed));
	endfunction

	function automatic addr_t io_addr(input logic [3:0] dev, input logic [2:0] idx);
		return {REGION_IO, dev, 16'h0000, 3'b000, idx, 2'b00};
	endfunction

	// One classic cycle that also checks the fixed ack latency of the region
	task automatic bus_cycle(input logic we, input addr_t adr, input word_t wdata,
			output word_t rdata);
		int   waited;
		int   expected_latency;
		logic acked;
		expected_latency = (adr[31:28] == REGION_IO) ? IO_LATENCY : NEAR_LATENCY;
		@(negedge clock);
		wb_cyc    = 1'b1;
		wb_stb    = 1'b1;
		wb_we     = we;
		wb_adr    = adr;
		wb_dat_in = wdata;
		waited    = 0;
		acked     = 1'b0;
		while (!acked && waited < ACK_LIMIT) begin
			@(negedge clock);
			waited++;
			acked = (wb_ack === 1'b1);
		end
		if (!acked) begin
			$display("No ack from the slave for address %h within %0d cycles", adr, ACK_LIMIT);
			$display("*** FAILED ***");
			$fatal(1, "bus timeout");
		end else begin
			rdata  = wb_dat_out;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we  = 1'b0;
			check_cycles($sformatf("ack latency at %h", adr), expected_latency, waited);
		end
	endtask

	task automatic bus_write(input addr_t adr, input word_t wdata);
		word_t unused;
		bus_cycle(1'b1, adr, wdata, unused);
	endtask

	task automatic bus_read(input addr_t adr, output word_t rdata);
		bus_cycle(1'b0, adr, '0, rdata);
	endtask

	//==================================================
	// Model helpers

	function automatic word_t expected_claim();
		logic [IRQ_SOURCES-1:0] active;
		active = pending_model & enable_model;
		for (int i = 0; i < IRQ_SOURCES; i++) begin
			if (active[i])
				return word_t'(i + 1);
		end
		return '0;
	endfunction

	// One-cycle pulse on the selected sources
	task automatic pulse_sources(input logic [IRQ_SOURCES-1:0] mask);
		@(negedge clock);
		irq_src = mask;
		@(negedge clock);
		irq_src = '0;
		pending_model = pending_model | mask;
	endtask

	task automatic wait_timer_irq(input logic level, input string name);
		int n;
		n = 0;
		while (irq_timer !== level && n < 8) begin
			@(negedge clock);
			n++;
		end
		check_bit(name, level, irq_timer);
	endtask

	//==================================================
	// Test sections

	task automatic test_rom_and_unmapped();
		word_t      rdata;
		word_t      draw;
		logic [3:0] region;
		for (int i = 0; i < N_ROM; i++) begin
			draw = next_word();
			bus_read({4'h0, draw[27:6], draw[5:2], 2'b00}, rdata);
			check_word($sformatf("rom index %0d", draw[5:2]), rom_model[draw[5:2]], rdata);
		end
		// Writes to ROM are acked and leave the image alone
		draw = next_word();
		bus_write({4'h0, 22'h0, draw[5:2], 2'b00}, ~rom_model[draw[5:2]]);
		bus_read({4'h0, 22'h0, draw[5:2], 2'b00}, rdata);
		check_word("rom after write", rom_model[draw[5:2]], rdata);
		for (int i = 0; i < N_UNMAPPED; i++) begin
			draw   = next_word();
			region = draw[31:28];
			if (region == REGION_ROM || region == REGION_IO)
				region = region + 4'h1;
			bus_read({region, draw[27:0]}, rdata);
			check_word($sformatf("unmapped %h", {region, draw[27:0]}), '0, rdata);
		end
		bus_write(32'hF000_0010, next_word());
	endtask

	task automatic test_sys_regs();
		word_t      rdata;
		word_t      wval;
		logic [3:0] code;
		bus_read(io_addr(DEV_SYSREG, SR_DEVICE_ID), rdata);
		check_word("device id", word_t'(DEVICE_ID), rdata);
		for (int i = 0; i < N_LED; i++) begin
			wval = next_word();
			bus_write(io_addr(DEV_SYSREG, SR_LEDS), wval);
			led_model = wval[LED_W-1:0];
			check_leds($sformatf("led pins %0d", i), led_model, leds);
			bus_read(io_addr(DEV_SYSREG, SR_LEDS), rdata);
			check_word($sformatf("led readback %0d", i), wval, rdata);
		end
		bus_read(io_addr(DEV_SYSREG, SR_RESET), rdata);
		check_word("reset switch read", '0, rdata);
		for (int i = 0; i < N_UNKNOWN; i++) begin
			wval = next_word();
			code = wval[3:0];
			while (code == DEV_TIMER || code == DEV_IRQ || code == DEV_SYSREG)
				code = code + 4'h1;
			bus_read(io_addr(code, wval[6:4]), rdata);
			check_word($sformatf("unknown device %h", code), '0, rdata);
		end
	endtask

	task automatic test_timer();
		word_t count_a;
		word_t count_b;
		word_t offset;
		word_t rdata;
		bus_write(io_addr(DEV_TIMER, TMR_CTRL), 32'h1);
		bus_read(io_addr(DEV_TIMER, TMR_COUNT), count_a);
		offset = next_word() & 32'hFF;
		bus_write(io_addr(DEV_TIMER, TMR_COMPARE), (count_a >= offset) ? count_a - offset : '0);
		wait_timer_irq(1'b1, "timer irq on compare match");
		bus_write(io_addr(DEV_TIMER, TMR_COMPARE), '1);
		wait_timer_irq(1'b0, "timer irq after compare reload");
		bus_read(io_addr(DEV_TIMER, TMR_COMPARE), rdata);
		check_word("timer compare readback", '1, rdata);
		bus_read(io_addr(DEV_TIMER, TMR_COUNT), count_a);
		bus_read(io_addr(DEV_TIMER, TMR_COUNT), count_b);
		check_bit("timer count increases", 1'b1, count_b > count_a);
		bus_write(io_addr(DEV_TIMER, TMR_CTRL), 32'h0);
	endtask

	task automatic test_irq_ctrl();
		word_t rdata;
		word_t draw;
		word_t expected;
		for (int round = 0; round < N_IRQ_ROUNDS; round++) begin
			draw = next_word();
			bus_write(io_addr(DEV_IRQ, IRQ_ENABLE), word_t'(draw[IRQ_SOURCES-1:0]));
			enable_model = draw[IRQ_SOURCES-1:0];
			check_bit("irq line after enable", |(pending_model & enable_model), irq_ext);
			pulse_sources(draw[IRQ_SOURCES+3:4]);
			check_bit("irq line after pulse", |(pending_model & enable_model), irq_ext);
			bus_read(io_addr(DEV_IRQ, IRQ_PENDING), rdata);
			check_word($sformatf("pending round %0d", round), word_t'(pending_model), rdata);
			// Let pending bits pile up over two rounds before claiming
			if (round % 2 == 1) begin
				while (expected_claim() != '0) begin
					expected = expected_claim();
					bus_read(io_addr(DEV_IRQ, IRQ_CLAIM), rdata);
					check_word($sformatf("claim round %0d", round), expected, rdata);
					pending_model[expected - 1] = 1'b0;
				end
				bus_read(io_addr(DEV_IRQ, IRQ_CLAIM), rdata);
				check_word("claim when idle", '0, rdata);
				check_bit("irq line after claims", |(pending_model & enable_model), irq_ext);
			end
		end
	endtask

	task automatic test_soft_reset();
		word_t rdata;
		word_t wval;
		wval = next_word() | 32'h1;
		bus_write(io_addr(DEV_SYSREG, SR_LEDS), wval);
		led_model = wval[LED_W-1:0];
		bus_write(io_addr(DEV_IRQ, IRQ_ENABLE), 32'hF);
		enable_model = '1;
		bus_write(io_addr(DEV_TIMER, TMR_CTRL), 32'h1);
		bus_write(io_addr(DEV_TIMER, TMR_COMPARE), '0);
		wait_timer_irq(1'b1, "timer irq before soft reset");
		bus_write(io_addr(DEV_SYSREG, SR_RESET), 32'h1);
		repeat (RESET_HOLD + 4) @(negedge clock);
		led_model     = '0;
		enable_model  = '0;
		pending_model = '0;
		check_leds("leds after soft reset", led_model, leds);
		check_bit("timer irq after soft reset", 1'b0, irq_timer);
		bus_read(io_addr(DEV_IRQ, IRQ_ENABLE), rdata);
		check_word("irq enable after soft reset", word_t'(enable_model), rdata);
		bus_read(io_addr(DEV_SYSREG, SR_LEDS), rdata);
		check_word("led register after soft reset", '0, rdata);
		bus_read(io_addr(DEV_IRQ, IRQ_PENDING), rdata);
		check_word("pending after soft reset", word_t'(pending_model), rdata);
	endtask

	//==================================================
	// Main sequence and watchdog

	initial begin
		seed          = 32'h7031_1eac;
		rst_n         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_in     = '0;
		irq_src       = '0;
		led_model     = '0;
		enable_model  = '0;
		pending_model = '0;
		$readmemh(ROM_FILE, rom_model);
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
		repeat (4) @(negedge clock);
		check_bit("ack after reset", 1'b0, wb_ack);
		check_bit("timer irq after reset", 1'b0, irq_timer);
		check_bit("ext irq after reset", 1'b0, irq_ext);
		check_leds("leds after reset", led_model, leds);

		test_rom_and_unmapped();
		test_sys_regs();
		test_timer();
		test_irq_ctrl();
		test_soft_reset();

		$display("*** PASSED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("*** FAILED ***");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

//--- list.f
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/reset_sync.sv
hdl/system_bus.sv
hdl/io_bridge.sv
hdl/sys_timer.sv
hdl/irq_ctrl.sv
hdl/sys_regs.sv
hdl/soc_top.sv
verif/tb_soc_top.sv

//--- rom_init.hex
// Boot ROM image, one 32-bit hex word per line, ROM index 0 to 15 in order
3C1D0000
27BDFFF0
AFBF000C
0C000010
00000000
8FBF000C
27BD0010
03E00008
00000000
3C085900
35080004
240A00A5
AD0A0000
1000FFFF
00000000
C0DEB007
